/* source/dmix_defs.svh */
`ifndef DMIX_DEFS_SVH
`define DMIX_DEFS_SVH

// audio and gain widths
`define DMIX_SAMPLE_W 24
`define DMIX_VOL_W 16
`define DMIX_VOL_UNITY 16'h8000
`define DMIX_RATE_W 4

// ring buffer geometry
`define DMIX_RB_DEPTH 16
`define DMIX_RB_LAG 8

// timers
`define DMIX_RST_CYCLES 16
`define DMIX_LED_HOLD 255

// spi register map
`define DMIX_REG_AW 7
`define DMIX_REG_VOL_L 7'd0
`define DMIX_REG_VOL_R 7'd1
`define DMIX_REG_STATUS 7'd2

`endif

/* source/dmix_pkg.sv */
`default_nettype none

package dmix_pkg;

`include "dmix_defs.svh"

    typedef logic signed [`DMIX_SAMPLE_W-1:0] sample_t;
    typedef logic [`DMIX_VOL_W-1:0] vol_t;

    // write frame, volume sits in the low bits of data
    typedef struct packed {
        logic we;
        logic [`DMIX_REG_AW-1:0] addr;
        logic [`DMIX_SAMPLE_W-1:0] data;
    } spi_wr_t;

    // read frame, only the address matters
    typedef struct packed {
        logic we;
        logic [`DMIX_REG_AW-1:0] addr;
        logic [`DMIX_SAMPLE_W-1:0] ign;
    } spi_rd_t;

    // one 32 bit spi word, msb first on the wire
    typedef union packed {
        spi_wr_t wr;
        spi_rd_t rd;
    } spi_frame_u;

endpackage

`default_nettype wire

/* source/dmix_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module dmix_ctrl (
    input  wire  clk245760,
    input  wire  dai_rst,
    input  wire  in_ack_i,
    input  wire  in_lrck_i,
    input  wire  in_locked_i,
    output logic core_rst_o,
    output logic we_l_o,
    output logic we_r_o,
    output logic flush_o,
    output logic mute_o,
    output logic led_o
);

    localparam int RST_W = $clog2(`DMIX_RST_CYCLES + 1);
    localparam int LED_W = $clog2(`DMIX_LED_HOLD + 1);

    logic [RST_W-1:0] rst_cnt;
    logic [LED_W-1:0] led_cnt;
    logic locked_q;

    // core reset stretched past the end of dai_rst
    always_ff @(posedge clk245760) begin
        if (dai_rst) begin
            rst_cnt <= '0;
            core_rst_o <= 1'b1;
        end else if (rst_cnt != RST_W'(`DMIX_RST_CYCLES)) begin
            rst_cnt <= rst_cnt + 1'b1;
        end else begin
            core_rst_o <= 1'b0;
        end
    end

    always_ff @(posedge clk245760) begin
        if (core_rst_o) begin
            we_l_o <= 1'b0;
            we_r_o <= 1'b0;
            flush_o <= 1'b0;
            mute_o <= 1'b1;
            led_o <= 1'b0;
            led_cnt <= '0;
            locked_q <= 1'b0;
        end else begin
            // lrck high marks a left sample
            we_l_o <= in_ack_i & in_lrck_i;
            we_r_o <= in_ack_i & ~in_lrck_i;
            // single pulse on lock loss
            locked_q <= in_locked_i;
            flush_o <= locked_q & ~in_locked_i;
            mute_o <= ~in_locked_i;
            // led waits for a stable lock
            if (!in_locked_i) begin
                led_cnt <= '0;
            end else if (led_cnt != LED_W'(`DMIX_LED_HOLD)) begin
                led_cnt <= led_cnt + 1'b1;
            end
            led_o <= in_locked_i && (led_cnt == LED_W'(`DMIX_LED_HOLD));
        end
    end

endmodule

`default_nettype wire

/* source/csr_spi.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module csr_spi (
    input  wire                     clk245760,
    input  wire                     core_rst_i,
    input  wire                     spi_sck_i,
    input  wire                     spi_mosi_i,
    input  wire                     spi_ss_i,
    input  wire                     locked_i,
    input  wire  [`DMIX_RATE_W-1:0] rate_i,
    output logic                    spi_miso_o,
    output dmix_pkg::vol_t          vol_l_o,
    output dmix_pkg::vol_t          vol_r_o
);

    localparam int FRAME_W = $bits(dmix_pkg::spi_frame_u);

    logic [2:0] sck_q;
    logic [2:0] ss_q;
    logic [1:0] mosi_q;
    logic sck_rise, sck_fall, ss_fall, ss_rise;
    logic [FRAME_W-1:0] rx_sh;
    logic [FRAME_W-1:0] tx_sh;
    logic [5:0] bit_cnt;
    logic [`DMIX_REG_AW-1:0] rd_addr;
    logic [`DMIX_SAMPLE_W-1:0] rd_word;
    dmix_pkg::spi_frame_u frame;

    // two flop sync, third stage for edges
    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            sck_q <= '0;
            ss_q <= '1;
            mosi_q <= '0;
        end else begin
            sck_q <= {sck_q[1:0], spi_sck_i};
            ss_q <= {ss_q[1:0], spi_ss_i};
            mosi_q <= {mosi_q[0], spi_mosi_i};
        end
    end

    assign sck_rise = sck_q[1] & ~sck_q[2] & ~ss_q[1];
    assign sck_fall = ~sck_q[1] & sck_q[2] & ~ss_q[1];
    assign ss_fall = ~ss_q[1] & ss_q[2];
    assign ss_rise = ss_q[1] & ~ss_q[2];
    assign frame = rx_sh;

    // readback source, address from the previous read frame
    always_comb begin
        case (rd_addr)
            `DMIX_REG_VOL_L:  rd_word = {{(`DMIX_SAMPLE_W - `DMIX_VOL_W){1'b0}}, vol_l_o};
            `DMIX_REG_VOL_R:  rd_word = {{(`DMIX_SAMPLE_W - `DMIX_VOL_W){1'b0}}, vol_r_o};
            `DMIX_REG_STATUS: rd_word = {{(`DMIX_SAMPLE_W - `DMIX_RATE_W - 1){1'b0}},
                                         locked_i, rate_i};
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            rx_sh <= '0;
            tx_sh <= '0;
            bit_cnt <= '0;
            rd_addr <= '0;
            vol_l_o <= `DMIX_VOL_UNITY;
            vol_r_o <= `DMIX_VOL_UNITY;
        end else if (ss_fall) begin
            bit_cnt <= '0;
            // first 8 bits out are zero
            tx_sh <= {{(FRAME_W - `DMIX_SAMPLE_W){1'b0}}, rd_word};
        end else if (ss_rise) begin
            tx_sh <= '0;
            if (bit_cnt == 6'(FRAME_W)) begin
                if (frame.wr.we) begin
                    case (frame.wr.addr)
                        `DMIX_REG_VOL_L: vol_l_o <= frame.wr.data[`DMIX_VOL_W-1:0];
                        `DMIX_REG_VOL_R: vol_r_o <= frame.wr.data[`DMIX_VOL_W-1:0];
                        default: ;
                    endcase
                end else begin
                    rd_addr <= frame.rd.addr;
                end
            end
        end else if (sck_rise) begin
            rx_sh <= {rx_sh[FRAME_W-2:0], mosi_q[1]};
            bit_cnt <= bit_cnt + 1'b1;
        end else if (sck_fall) begin
            tx_sh <= {tx_sh[FRAME_W-2:0], 1'b0};
        end
    end

    assign spi_miso_o = tx_sh[FRAME_W-1];

endmodule

`default_nettype wire

/* source/ringbuf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module ringbuf (
    input  wire               clk245760,
    input  wire               core_rst_i,
    input  wire               flush_i,
    input  wire               we_i,
    input  dmix_pkg::sample_t data_i,
    input  wire               pop_i,
    output dmix_pkg::sample_t data_o,
    output logic              ack_o
);

    localparam int AW = $clog2(`DMIX_RB_DEPTH);
    // newest entry sits at wr_ptr - 1
    localparam logic [AW-1:0] RD_OFS = AW'(`DMIX_RB_LAG + 1);

    dmix_pkg::sample_t mem [`DMIX_RB_DEPTH];
    logic [`DMIX_RB_DEPTH-1:0] valid;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    assign rd_ptr = wr_ptr - RD_OFS;

    always_ff @(posedge clk245760) begin
        if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
        // entries not written since flush read as silence
        if (pop_i) begin
            data_o <= valid[rd_ptr] ? mem[rd_ptr] : '0;
        end
    end

    always_ff @(posedge clk245760) begin
        if (core_rst_i || flush_i) begin
            valid <= '0;
            wr_ptr <= '0;
        end else if (we_i) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= pop_i;
        end
    end

endmodule

`default_nettype wire

/* source/vol_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module vol_mixer (
    input  wire               clk245760,
    input  wire               core_rst_i,
    input  wire               mute_i,
    input  wire  [1:0]        pop_i,
    input  dmix_pkg::sample_t rb_data_l_i,
    input  dmix_pkg::sample_t rb_data_r_i,
    input  wire               rb_ack_l_i,
    input  wire               rb_ack_r_i,
    input  dmix_pkg::vol_t    vol_l_i,
    input  dmix_pkg::vol_t    vol_r_i,
    output logic              rb_pop_l_o,
    output logic              rb_pop_r_o,
    output dmix_pkg::sample_t data_o,
    output logic [1:0]        ack_o
);

    dmix_pkg::sample_t sel_data;
    dmix_pkg::vol_t sel_vol;
    dmix_pkg::vol_t gain;
    logic signed [`DMIX_SAMPLE_W+`DMIX_VOL_W:0] product;

    // bit 0 is left, bit 1 is right
    assign rb_pop_l_o = pop_i[0];
    assign rb_pop_r_o = pop_i[1];

    always_comb begin
        sel_data = rb_ack_r_i ? rb_data_r_i : rb_data_l_i;
        sel_vol = rb_ack_r_i ? vol_r_i : vol_l_i;
        // no boost above unity
        gain = (sel_vol > `DMIX_VOL_UNITY) ? `DMIX_VOL_UNITY : sel_vol;
        product = sel_data * $signed({1'b0, gain});
    end

    // dropping the low 15 bits floors the result
    always_ff @(posedge clk245760) begin
        data_o <= mute_i ? '0 : product[15 +: `DMIX_SAMPLE_W];
    end

    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            ack_o <= '0;
        end else begin
            ack_o <= {rb_ack_r_i, rb_ack_l_i};
        end
    end

endmodule

`default_nettype wire

/* source/dac_drv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module dac_drv (
    input  wire               clk245760,
    input  wire               core_rst_i,
    input  dmix_pkg::sample_t data_i,
    input  wire  [1:0]        ack_i,
    output logic [1:0]        pop_o,
    output logic              dac_sck_o,
    output logic              dac_bck_o,
    output logic              dac_lrck_o,
    output logic              dac_data_o
);

    // 512 clocks per frame, 8 clocks per bck
    logic [8:0] cnt;
    dmix_pkg::sample_t sample_l;
    dmix_pkg::sample_t sample_r;
    dmix_pkg::sample_t shreg;

    assign dac_sck_o = cnt[0];
    assign dac_bck_o = cnt[2];
    assign dac_lrck_o = cnt[8];

    // each channel fetched 8 clocks ahead of its lrck edge
    assign pop_o[0] = (cnt == 9'd504);
    assign pop_o[1] = (cnt == 9'd248);

    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            cnt <= '0;
            sample_l <= '0;
            sample_r <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            if (ack_i[0]) begin
                sample_l <= data_i;
            end
            if (ack_i[1]) begin
                sample_r <= data_i;
            end
        end
    end

    // data moves on bck fall, one slot of delay after lrck
    always_ff @(posedge clk245760) begin
        if (core_rst_i) begin
            shreg <= '0;
            dac_data_o <= 1'b0;
        end else if (cnt[7:0] == 8'hff) begin
            dac_data_o <= 1'b0;
            shreg <= cnt[8] ? sample_l : sample_r;
        end else if (cnt[2:0] == 3'd7) begin
            dac_data_o <= shreg[`DMIX_SAMPLE_W-1];
            shreg <= {shreg[`DMIX_SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* source/dmix_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module dmix_top (
    input  wire                     clk245760,
    input  wire                     dai_rst,
    input  dmix_pkg::sample_t       in_data_i,
    input  wire                     in_ack_i,
    input  wire                     in_lrck_i,
    input  wire                     in_locked_i,
    input  wire  [`DMIX_RATE_W-1:0] in_rate_i,
    input  wire                     spi_sck_i,
    input  wire                     spi_mosi_i,
    input  wire                     spi_ss_i,
    output logic                    spi_miso_o,
    output logic                    dac_sck_o,
    output logic                    dac_bck_o,
    output logic                    dac_lrck_o,
    output logic                    dac_data_o,
    output logic                    led_o
);

    logic core_rst, we_l, we_r, flush, mute;
    logic rb_pop_l, rb_pop_r, rb_ack_l, rb_ack_r;
    logic [1:0] pop, ack;
    dmix_pkg::sample_t rb_data_l, rb_data_r, mix_data;
    dmix_pkg::vol_t vol_l, vol_r;

    dmix_ctrl u_ctrl (
        .clk245760(clk245760), .dai_rst(dai_rst),
        .in_ack_i(in_ack_i), .in_lrck_i(in_lrck_i), .in_locked_i(in_locked_i),
        .core_rst_o(core_rst), .we_l_o(we_l), .we_r_o(we_r),
        .flush_o(flush), .mute_o(mute), .led_o(led_o));

    csr_spi u_csr (
        .clk245760(clk245760), .core_rst_i(core_rst),
        .spi_sck_i(spi_sck_i), .spi_mosi_i(spi_mosi_i), .spi_ss_i(spi_ss_i),
        .locked_i(in_locked_i), .rate_i(in_rate_i),
        .spi_miso_o(spi_miso_o), .vol_l_o(vol_l), .vol_r_o(vol_r));

    ringbuf u_rb_l (
        .clk245760(clk245760), .core_rst_i(core_rst), .flush_i(flush),
        .we_i(we_l), .data_i(in_data_i),
        .pop_i(rb_pop_l), .data_o(rb_data_l), .ack_o(rb_ack_l));

    ringbuf u_rb_r (
        .clk245760(clk245760), .core_rst_i(core_rst), .flush_i(flush),
        .we_i(we_r), .data_i(in_data_i),
        .pop_i(rb_pop_r), .data_o(rb_data_r), .ack_o(rb_ack_r));

    vol_mixer u_mix (
        .clk245760(clk245760), .core_rst_i(core_rst), .mute_i(mute), .pop_i(pop),
        .rb_data_l_i(rb_data_l), .rb_data_r_i(rb_data_r),
        .rb_ack_l_i(rb_ack_l), .rb_ack_r_i(rb_ack_r),
        .vol_l_i(vol_l), .vol_r_i(vol_r),
        .rb_pop_l_o(rb_pop_l), .rb_pop_r_o(rb_pop_r),
        .data_o(mix_data), .ack_o(ack));

    dac_drv u_dac (
        .clk245760(clk245760), .core_rst_i(core_rst),
        .data_i(mix_data), .ack_i(ack), .pop_o(pop),
        .dac_sck_o(dac_sck_o), .dac_bck_o(dac_bck_o),
        .dac_lrck_o(dac_lrck_o), .dac_data_o(dac_data_o));

endmodule

`default_nettype wire

/* test/dmix_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmix_defs.svh"

module dmix_tb;

    localparam int NROWS = 16;
    // columns: left, right, vol_l, vol_r
    localparam logic [79:0] ROWS [NROWS] = '{
        80'h7fff00_800100_8000_8000, 80'h123400_fedc00_8000_8000,
        80'h400000_c00000_8000_8000, 80'h0abc00_f54300_8000_8000,
        80'h3fff00_b00000_8000_8000, 80'h000100_ffff00_8000_8000,
        80'h555500_aaaa00_8000_8000, 80'h700000_900000_8000_8000,
        80'h010000_ff0000_8000_8000, 80'h2468a0_db9760_8000_8000,
        80'h135700_eca900_4000_2001, 80'h654300_9abd00_4000_2001,
        80'h111100_eeef00_ffff_9000, 80'h222200_dddd00_ffff_9000,
        80'h333300_cccc00_0000_7fff, 80'h444400_bbbb00_0000_7fff
    };

    logic clk245760 = 1'b0;
    logic dai_rst;
    dmix_pkg::sample_t in_data_i;
    logic in_ack_i, in_lrck_i, in_locked_i;
    logic [`DMIX_RATE_W-1:0] in_rate_i;
    logic spi_sck_i, spi_mosi_i, spi_ss_i, spi_miso_o;
    logic dac_sck_o, dac_bck_o, dac_lrck_o, dac_data_o, led_o;

    int errors = 0;
    int checks = 0;
    int timeouts = 0;
    logic [15:0] lfsr = 16'd41087;
    dmix_pkg::sample_t fed_l [$];
    dmix_pkg::sample_t fed_r [$];
    dmix_pkg::vol_t cur_vl, cur_vr;

    always #50 clk245760 = ~clk245760;

    dmix_top u_dmix_top (
        .clk245760(clk245760), .dai_rst(dai_rst),
        .in_data_i(in_data_i), .in_ack_i(in_ack_i), .in_lrck_i(in_lrck_i),
        .in_locked_i(in_locked_i), .in_rate_i(in_rate_i),
        .spi_sck_i(spi_sck_i), .spi_mosi_i(spi_mosi_i), .spi_ss_i(spi_ss_i),
        .spi_miso_o(spi_miso_o), .dac_sck_o(dac_sck_o), .dac_bck_o(dac_bck_o),
        .dac_lrck_o(dac_lrck_o), .dac_data_o(dac_data_o), .led_o(led_o));

    task automatic check_sample(input string name, input dmix_pkg::sample_t got,
                                input dmix_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_vol(input string name, input dmix_pkg::vol_t got,
                             input dmix_pkg::vol_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [23:0] got,
                                input logic [23:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        timeouts++;
        $display("timeout: %s", what);
        $display("errors %0d, timeouts %0d, checks %0d", errors, timeouts, checks);
        $display("TEST FAILED");
        $finish;
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        int k;
        b = '0;
        for (k = 0; k < 8; k++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return b;
    endfunction

    // gain clamped to unity, product floored after dropping 15 bits
    function automatic dmix_pkg::sample_t scale(input dmix_pkg::sample_t s,
                                                input dmix_pkg::vol_t v);
        longint g;
        longint p;
        g = (v > `DMIX_VOL_UNITY) ? 64'sd32768 : longint'(v);
        p = longint'(s) * g;
        p = p >>> 15;
        return p[`DMIX_SAMPLE_W-1:0];
    endfunction

    function automatic dmix_pkg::sample_t expected_word(input bit right,
                                                        input dmix_pkg::vol_t v);
        int n;
        dmix_pkg::sample_t s;
        n = right ? fed_r.size() : fed_l.size();
        if (n <= `DMIX_RB_LAG) begin
            return '0;
        end
        s = right ? fed_r[n-1-`DMIX_RB_LAG] : fed_l[n-1-`DMIX_RB_LAG];
        return scale(s, v);
    endfunction

    // mode 0 at clk/16, miso taken just before each rising sck
    task automatic spi_xfer(input dmix_pkg::spi_frame_u tx, output logic [31:0] rx);
        int b;
        rx = '0;
        @(posedge clk245760);
        spi_ss_i <= 1'b0;
        for (b = 31; b >= 0; b--) begin
            spi_mosi_i <= tx[b];
            repeat (8) @(posedge clk245760);
            rx = {rx[30:0], spi_miso_o};
            spi_sck_i <= 1'b1;
            repeat (8) @(posedge clk245760);
            spi_sck_i <= 1'b0;
        end
        repeat (8) @(posedge clk245760);
        spi_ss_i <= 1'b1;
        repeat (8) @(posedge clk245760);
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [23:0] data);
        dmix_pkg::spi_frame_u f;
        logic [31:0] rx;
        f.wr.we = 1'b1;
        f.wr.addr = addr;
        f.wr.data = data;
        spi_xfer(f, rx);
    endtask

    // returns the register named by the previous read frame
    task automatic read_reg(input logic [6:0] addr, output logic [23:0] prev);
        dmix_pkg::spi_frame_u f;
        logic [31:0] rx;
        f.rd.we = 1'b0;
        f.rd.addr = addr;
        f.rd.ign = '0;
        spi_xfer(f, rx);
        prev = rx[23:0];
    endtask

    task automatic feed_pair(input dmix_pkg::sample_t l, input dmix_pkg::sample_t r);
        @(posedge clk245760);
        in_data_i <= l;
        in_lrck_i <= 1'b1;
        in_ack_i <= 1'b1;
        @(posedge clk245760);
        in_ack_i <= 1'b0;
        @(posedge clk245760);
        in_data_i <= r;
        in_lrck_i <= 1'b0;
        in_ack_i <= 1'b1;
        @(posedge clk245760);
        in_ack_i <= 1'b0;
        @(posedge clk245760);
        fed_l.push_back(l);
        fed_r.push_back(r);
    endtask

    // i2s pins sampled mid cycle, data taken on rising bck
    task automatic capture_frame(output dmix_pkg::sample_t l, output dmix_pkg::sample_t r);
        int cyc;
        int kl;
        int kr;
        logic lr_q;
        logic bck_q;
        cyc = 0;
        kl = 0;
        kr = 0;
        l = '0;
        r = '0;
        @(negedge clk245760);
        lr_q = dac_lrck_o;
        @(negedge clk245760);
        while (!(lr_q && !dac_lrck_o)) begin
            if (cyc > 1100) timeout_abort("no falling lrck edge from the DAC");
            lr_q = dac_lrck_o;
            @(negedge clk245760);
            cyc++;
        end
        cyc = 0;
        bck_q = dac_bck_o;
        while (kr < 25) begin
            @(negedge clk245760);
            cyc++;
            if (cyc > 600) timeout_abort("DAC frame did not complete");
            if (dac_bck_o && !bck_q) begin
                // first bck of each half is the empty slot
                if (!dac_lrck_o) begin
                    kl++;
                    if (kl >= 2 && kl <= 25) l = {l[22:0], dac_data_o};
                end else begin
                    kr++;
                    if (kr >= 2) r = {r[22:0], dac_data_o};
                end
            end
            bck_q = dac_bck_o;
        end
    endtask

    task automatic run_rows(input int first, input int last);
        int i;
        dmix_pkg::sample_t l, r, got_l, got_r;
        dmix_pkg::vol_t vl, vr;
        // line up with the frame so feeds land clear of the pops
        capture_frame(got_l, got_r);
        for (i = first; i <= last; i++) begin
            vl = ROWS[i][31:16];
            vr = ROWS[i][15:0];
            if (vl != cur_vl || vr != cur_vr) begin
                write_reg(`DMIX_REG_VOL_L, {8'h00, vl});
                write_reg(`DMIX_REG_VOL_R, {8'h00, vr});
                cur_vl = vl;
                cur_vr = vr;
                capture_frame(got_l, got_r);
            end
            l = ROWS[i][79:56] ^ {16'h0000, rand_byte()};
            r = ROWS[i][55:32] ^ {16'h0000, rand_byte()};
            feed_pair(l, r);
            capture_frame(got_l, got_r);
            check_sample("dac_data_o left", got_l, expected_word(1'b0, vl));
            check_sample("dac_data_o right", got_r, expected_word(1'b1, vr));
        end
    endtask

    initial begin : main
        dmix_pkg::sample_t got_l, got_r;
        logic [23:0] word;
        logic sck_q;
        int k;
        int cyc;
        dai_rst = 1'b1;
        in_data_i = '0;
        in_ack_i = 1'b0;
        in_lrck_i = 1'b0;
        in_locked_i = 1'b1;
        in_rate_i = 4'h5;
        spi_sck_i = 1'b0;
        spi_mosi_i = 1'b0;
        spi_ss_i = 1'b1;
        repeat (5) @(posedge clk245760);
        dai_rst <= 1'b0;
        // core reset still held
        for (k = 0; k < `DMIX_RST_CYCLES - 2; k++) begin
            @(negedge clk245760);
            check_bit("dac_sck_o", dac_sck_o, 1'b0);
            check_bit("dac_bck_o", dac_bck_o, 1'b0);
            check_bit("dac_lrck_o", dac_lrck_o, 1'b0);
            check_bit("dac_data_o", dac_data_o, 1'b0);
            check_bit("led_o", led_o, 1'b0);
            check_bit("spi_miso_o", spi_miso_o, 1'b0);
        end
        for (k = 0; k < 2; k++) begin
            capture_frame(got_l, got_r);
            check_sample("dac_data_o left", got_l, '0);
            check_sample("dac_data_o right", got_r, '0);
        end

        // sck runs at half the master clock
        @(negedge clk245760);
        sck_q = dac_sck_o;
        for (k = 0; k < 16; k++) begin
            @(negedge clk245760);
            check_bit("dac_sck_o", dac_sck_o, ~sck_q);
            sck_q = dac_sck_o;
        end

        write_reg(`DMIX_REG_VOL_L, 24'h001234);
        write_reg(`DMIX_REG_VOL_R, 24'h00abcd);
        cur_vl = 16'h1234;
        cur_vr = 16'habcd;
        read_reg(`DMIX_REG_VOL_L, word);
        read_reg(`DMIX_REG_VOL_R, word);
        check_vol("vol_l", word[15:0], 16'h1234);
        read_reg(`DMIX_REG_STATUS, word);
        check_vol("vol_r", word[15:0], 16'habcd);
        read_reg(`DMIX_REG_STATUS, word);
        check_status("status", word, 24'h000015);

        run_rows(0, NROWS - 1);
        check_bit("led_o", led_o, 1'b1);

        // lock loss flushes both buffers
        @(posedge clk245760);
        in_locked_i <= 1'b0;
        in_rate_i <= 4'ha;
        fed_l.delete();
        fed_r.delete();
        for (k = 0; k < 2; k++) begin
            capture_frame(got_l, got_r);
            check_sample("dac_data_o left", got_l, '0);
            check_sample("dac_data_o right", got_r, '0);
            check_bit("led_o", led_o, 1'b0);
        end
        read_reg(`DMIX_REG_STATUS, word);
        read_reg(`DMIX_REG_STATUS, word);
        check_status("status", word, 24'h00000a);
        check_bit("led_o", led_o, 1'b0);

        @(posedge clk245760);
        in_locked_i <= 1'b1;
        cyc = 0;
        while (led_o !== 1'b1) begin
            if (cyc > `DMIX_LED_HOLD + 8) timeout_abort("led_o stayed off after relock");
            @(negedge clk245760);
            cyc++;
        end
        if (cyc < `DMIX_LED_HOLD) begin
            errors++;
            $display("led_o came on after only %0d cycles of lock", cyc);
        end
        run_rows(0, 11);
        check_bit("led_o", led_o, 1'b1);

        $display("errors %0d, timeouts %0d, checks %0d", errors, timeouts, checks);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/dmix_pkg.sv
source/dmix_ctrl.sv
source/csr_spi.sv
source/ringbuf.sv
source/vol_mixer.sv
source/dac_drv.sv
source/dmix_top.sv
test/dmix_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module dmix_tb -o vdmix_tb

output=$(./obj_dir/vdmix_tb)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
